// File: Bender.yml
package:
  name: cjtag_bridge

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/cjtag_pkg.sv
      - verilog/cjtag_input_sync.sv
      - verilog/cjtag_escape_detect.sv
      - verilog/cjtag_ctrl_fsm.sv
      - verilog/oscan1_tap_drive.sv
      - verilog/cjtag_bridge.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/cjtag_bridge_properties.sv
      - verification/tb_cjtag_bridge.sv

// File: compile.f
+incdir+include
verilog/cjtag_pkg.sv
verilog/cjtag_input_sync.sv
verilog/cjtag_escape_detect.sv
verilog/cjtag_ctrl_fsm.sv
verilog/oscan1_tap_drive.sv
verilog/cjtag_bridge.sv
verification/cjtag_bridge_properties.sv
verification/tb_cjtag_bridge.sv

// File: include/cjtag_settings.svh
/*
 * Protocol constants for the cJTAG to JTAG bridge
 * Synchronizer depth, toggle counter width, escape thresholds, activation code
 */
`ifndef CJTAG_SETTINGS_SVH
`define CJTAG_SETTINGS_SVH

// ============================================================
// Input synchronization
// ============================================================

// Flop stages per probe pin before edge detection
`define CJTAG_SYNC_STAGES 2

// ============================================================
// Escape sequences
// ============================================================

// Toggle counter width, saturates well above the reset threshold
`define CJTAG_TOGGLE_CNT_W 5

// Selection escape window, inclusive on both ends
`define CJTAG_ESC_SELECT_MIN 6
`define CJTAG_ESC_SELECT_MAX 7

// Reset escape, this count or more
`define CJTAG_ESC_RESET_MIN 8

// ============================================================
// Online activation code
// ============================================================

// Code length and value, sent LSB first by the probe
`define CJTAG_OAC_BITS 4
`define CJTAG_OAC 4'b1011

`endif

// File: verification/cjtag_bridge_properties.sv
/*
 * Concurrent assertions on the JTAG and TMSC pins, bound to the bridge top
 */
`timescale 1ns/1ps
`default_nettype none

module cjtag_bridge_properties (
    input logic                   clk_i,
    input logic                   ntrst_i,
    input logic                   tmsc_out_i,
    input logic                   tmsc_oen_i,
    input logic                   tck_i,
    input logic                   online_i,
    input logic                   nsp_i,
    input cjtag_pkg::oscan1_pos_t pkt_pos_i
);

    import cjtag_pkg::*;

    // TMSC output stays low while the probe owns the line
    tmsc_low_as_input: assert property (
        @(posedge clk_i) disable iff (!ntrst_i) tmsc_oen_i |-> !tmsc_out_i
    ) else $error("tmsc_o high while tmsc_oen_o selects input");

    // No TAP clock unless the bridge is online
    tck_only_online: assert property (
        @(posedge clk_i) disable iff (!ntrst_i) !online_i |-> !tck_i
    ) else $error("tck_o high while offline");

    // Status pins are complements
    nsp_inverse: assert property (
        @(posedge clk_i) disable iff (!ntrst_i) nsp_i == !online_i
    ) else $error("nsp_o is not the inverse of online_o");

    // TCK only starts in the third packet bit
    tck_in_tdo_slot: assert property (
        @(posedge clk_i) disable iff (!ntrst_i) $rose(tck_i) |-> pkt_pos_i == POS_TDO
    ) else $error("tck_o rose outside the TDO slot");

endmodule

bind cjtag_bridge cjtag_bridge_properties u_properties (
    .clk_i      (clk_i),
    .ntrst_i    (ntrst_i),
    .tmsc_out_i (tmsc_o),
    .tmsc_oen_i (tmsc_oen_o),
    .tck_i      (tck_o),
    .online_i   (online_o),
    .nsp_i      (nsp_o),
    .pkt_pos_i  (pkt_pos)
);

`default_nettype wire

// File: verification/tb_cjtag_bridge.sv
/*
 * Directed testbench for the cJTAG to JTAG bridge
 * Probe driver tasks, escape, activation and OScan1 packet tests, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

`include "cjtag_settings.svh"

module tb_cjtag_bridge;

    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DLY    = 2;
    localparam int RST_CYCLES   = 16;
    localparam int N_PACKETS    = 8;
    // Deselection escape has no effect on the bridge
    localparam int ESC_DESELECT = 4;
    localparam logic [`CJTAG_OAC_BITS-1:0] BAD_OAC = 4'b1001;

    // Run budget in TCKC cycles of 10 clocks with one escape counted as 5 cycles
    localparam int ESC_CYCLES  = 5 * 5;
    localparam int ACT_CYCLES  = 4 * `CJTAG_OAC_BITS;
    localparam int PKT_CYCLES  = N_PACKETS * 3;
    localparam int TCKC_CYCLES = ESC_CYCLES + ACT_CYCLES + PKT_CYCLES;
    localparam int MARGIN_CLKS = 200;
    localparam int TIMEOUT_NS  = (RST_CYCLES + TCKC_CYCLES * 10 + MARGIN_CLKS) * CLK_PERIOD;

    logic clk_i;
    logic ntrst_i;
    logic tckc_i;
    logic tmsc_i;
    logic tdo_i;
    logic tmsc_o;
    logic tmsc_oen_o;
    logic tck_o;
    logic tms_o;
    logic tdi_o;
    logic online_o;
    logic nsp_o;

    int          err_cnt;
    int          check_cnt;
    string       test_name;
    logic [31:0] lcg_state;

    cjtag_bridge u_cjtag_bridge (
        .clk_i      (clk_i),
        .ntrst_i    (ntrst_i),
        .tckc_i     (tckc_i),
        .tmsc_i     (tmsc_i),
        .tmsc_o     (tmsc_o),
        .tmsc_oen_o (tmsc_oen_o),
        .tck_o      (tck_o),
        .tms_o      (tms_o),
        .tdi_o      (tdi_o),
        .tdo_i      (tdo_i),
        .online_o   (online_o),
        .nsp_o      (nsp_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ============================================================
    // Helpers and checks
    // ============================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        lcg_next = state * 32'd1103515245 + 32'd12345;
    endfunction

    // Upper LCG bits have the longest period
    task automatic random_bit(output logic bit_o);
        lcg_state = lcg_next(lcg_state);
        bit_o = lcg_state[30];
    endtask

    // Inputs move a little after the rising edge
    task automatic next_drive();
        @(posedge clk_i);
        #(DRIVE_DLY);
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error %s: %s expected %0b actual %0b", test_name, what, exp, act);
        end
    endtask

    task automatic check_state(input logic exp_online, input logic exp_nsp);
        check_cnt++;
        if ({online_o, nsp_o} !== {exp_online, exp_nsp}) begin
            err_cnt++;
            $display("error %s: online/nsp expected %0b/%0b actual %0b/%0b",
                     test_name, exp_online, exp_nsp, online_o, nsp_o);
        end
    endtask

    // ============================================================
    // Probe driver tasks
    // ============================================================

    // One TCKC period of 5 clocks high then 5 low with TMSC set at the rise
    // Outputs are sampled on the falling clock edge and TDO is kept while TCK is high
    task automatic tckc_cycle(input logic tmsc_val, output logic tck_seen,
                              output logic oen_seen, output logic tmsc_read);
        int i;
        tck_seen  = 1'b0;
        oen_seen  = 1'b0;
        tmsc_read = 1'bx;
        tckc_i    = 1'b1;
        tmsc_i    = tmsc_val;
        for (i = 0; i < 10; i++) begin
            if (i == 5) begin
                tckc_i = 1'b0;
            end
            @(negedge clk_i);
            if (tck_o) begin
                tck_seen = 1'b1;
            end
            if (!tmsc_oen_o) begin
                oen_seen = 1'b1;
                if (tck_o) begin
                    tmsc_read = tmsc_o;
                end
            end
            next_drive();
        end
    endtask

    task automatic send_bit(input logic b);
        logic tck_seen;
        logic oen_seen;
        logic tmsc_read;
        tckc_cycle(b, tck_seen, oen_seen, tmsc_read);
    endtask

    // TMSC toggles 4 clocks apart while TCKC is held high
    task automatic send_escape(input int toggles);
        int i;
        tckc_i = 1'b1;
        repeat (4) next_drive();
        for (i = 0; i < toggles; i++) begin
            tmsc_i = ~tmsc_i;
            repeat (4) next_drive();
        end
        tckc_i = 1'b0;
        repeat (6) next_drive();
    endtask

    // Activation code goes out LSB first
    task automatic send_code(input logic [`CJTAG_OAC_BITS-1:0] code);
        int i;
        for (i = 0; i < `CJTAG_OAC_BITS; i++) begin
            send_bit(code[i]);
        end
    endtask

    // Sends nTDI and TMS before the TCK slot in which the bridge returns TDO on TMSC
    task automatic send_packet(input logic ntdi, input logic tms, input logic tdo);
        logic tck_seen;
        logic oen_seen;
        logic tmsc_read;
        tdo_i = tdo;
        send_bit(ntdi);
        send_bit(tms);
        tckc_cycle(tms, tck_seen, oen_seen, tmsc_read);
        if (!oen_seen) begin
            err_cnt++;
            $display("%s: the bridge never drove TMSC during the TDO bit", test_name);
        end
        check_bit("tck pulse", 1'b1, tck_seen);
        check_bit("tdo on tmsc", tdo, tmsc_read);
        check_bit("tdi", ~ntdi, tdi_o);
        check_bit("tms", tms, tms_o);
        check_bit("tck idle", 1'b0, tck_o);
    endtask

    // ============================================================
    // Directed tests
    // ============================================================

    task automatic test_reset_values();
        test_name = "reset_values";
        check_state(1'b0, 1'b1);
        check_bit("tck", 1'b0, tck_o);
        check_bit("tms", 1'b1, tms_o);
        check_bit("tdi", 1'b0, tdi_o);
        check_bit("tmsc_o", 1'b0, tmsc_o);
        check_bit("tmsc_oen", 1'b1, tmsc_oen_o);
    endtask

    task automatic test_ignored_escapes();
        test_name = "ignored_escapes";
        send_escape(ESC_DESELECT);
        // A valid code only activates the bridge if the escape was taken as a selection
        send_code(`CJTAG_OAC);
        check_state(1'b0, 1'b1);
        // Valid selection followed by a wrong code
        send_escape(`CJTAG_ESC_SELECT_MIN);
        send_code(BAD_OAC);
        check_state(1'b0, 1'b1);
        check_bit("tmsc_oen", 1'b1, tmsc_oen_o);
    endtask

    task automatic test_activation();
        test_name = "activation";
        send_escape(`CJTAG_ESC_SELECT_MIN);
        send_code(`CJTAG_OAC);
        check_state(1'b1, 1'b0);
        check_bit("tck", 1'b0, tck_o);
        check_bit("tmsc_oen", 1'b1, tmsc_oen_o);
    endtask

    task automatic test_packets();
        int   n;
        logic ntdi;
        logic tms;
        logic tdo;
        test_name = "oscan1_packets";
        for (n = 0; n < N_PACKETS; n++) begin
            random_bit(ntdi);
            random_bit(tms);
            random_bit(tdo);
            send_packet(ntdi, tms, tdo);
        end
    endtask

    task automatic test_reset_escape();
        test_name = "reset_escape";
        send_escape(`CJTAG_ESC_RESET_MIN);
        check_state(1'b0, 1'b1);
        check_bit("tck", 1'b0, tck_o);
        check_bit("tms", 1'b1, tms_o);
        check_bit("tmsc_oen", 1'b1, tmsc_oen_o);
        // Bridge comes back online after a fresh activation
        send_escape(`CJTAG_ESC_SELECT_MIN);
        send_code(`CJTAG_OAC);
        check_state(1'b1, 1'b0);
    endtask

    // ============================================================
    // Main sequence and watchdog
    // ============================================================

    initial begin
        clk_i     = 1'b0;
        ntrst_i   = 1'b0;
        tckc_i    = 1'b0;
        tmsc_i    = 1'b0;
        tdo_i     = 1'b0;
        err_cnt   = 0;
        check_cnt = 0;
        lcg_state = 32'd14170;
        test_name = "init";
        repeat (RST_CYCLES) @(posedge clk_i);
        #(DRIVE_DLY);
        ntrst_i = 1'b1;
        next_drive();
        test_reset_values();
        test_ignored_escapes();
        test_activation();
        test_packets();
        test_reset_escape();
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout in test %s, the run did not complete in time", test_name);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/cjtag_bridge.sv
/*
 * cJTAG (TCKC/TMSC) to JTAG (TCK/TMS/TDI/TDO) bridge, OScan1 subset
 * Connects synchronizers, escape detector, controller and TAP drive
 */
`timescale 1ns/1ps
`default_nettype none

module cjtag_bridge (
    input  logic clk_i,
    input  logic ntrst_i,
    // Probe side, asynchronous to clk_i
    input  logic tckc_i,
    input  logic tmsc_i,
    output logic tmsc_o,
    // Output enable, 0 drives TMSC and 1 leaves it as input
    output logic tmsc_oen_o,
    // TAP side
    output logic tck_o,
    output logic tms_o,
    output logic tdi_o,
    input  logic tdo_i,
    // Status
    output logic online_o,
    output logic nsp_o
);

    logic tckc_lvl;
    logic tmsc_lvl;
    logic tckc_rise;
    logic tckc_fall;
    logic tmsc_edge;
    logic esc_select;
    logic esc_reset;
    logic oscan_active;
    logic tmsc_bit;

    cjtag_pkg::oscan1_pos_t pkt_pos;

    // Pin edges reach the JTAG pins 4 clocks later
    cjtag_input_sync u_input_sync (
        .clk_i       (clk_i),
        .ntrst_i     (ntrst_i),
        .tckc_i      (tckc_i),
        .tmsc_i      (tmsc_i),
        .tckc_lvl_o  (tckc_lvl),
        .tmsc_lvl_o  (tmsc_lvl),
        .tckc_rise_o (tckc_rise),
        .tckc_fall_o (tckc_fall),
        .tmsc_edge_o (tmsc_edge)
    );

    cjtag_escape_detect u_escape_detect (
        .clk_i        (clk_i),
        .ntrst_i      (ntrst_i),
        .tckc_lvl_i   (tckc_lvl),
        .tckc_rise_i  (tckc_rise),
        .tckc_fall_i  (tckc_fall),
        .tmsc_edge_i  (tmsc_edge),
        .esc_select_o (esc_select),
        .esc_reset_o  (esc_reset)
    );

    cjtag_ctrl_fsm u_ctrl_fsm (
        .clk_i          (clk_i),
        .ntrst_i        (ntrst_i),
        .tmsc_lvl_i     (tmsc_lvl),
        .tckc_fall_i    (tckc_fall),
        .esc_select_i   (esc_select),
        .esc_reset_i    (esc_reset),
        .oscan_active_o (oscan_active),
        .pkt_pos_o      (pkt_pos),
        .tmsc_bit_o     (tmsc_bit),
        .online_o       (online_o),
        .nsp_o          (nsp_o)
    );

    oscan1_tap_drive u_tap_drive (
        .clk_i          (clk_i),
        .ntrst_i        (ntrst_i),
        .oscan_active_i (oscan_active),
        .pkt_pos_i      (pkt_pos),
        .tmsc_bit_i     (tmsc_bit),
        .tckc_rise_i    (tckc_rise),
        .tckc_fall_i    (tckc_fall),
        .tdo_i          (tdo_i),
        .tck_o          (tck_o),
        .tms_o          (tms_o),
        .tdi_o          (tdi_o),
        .tmsc_o         (tmsc_o),
        .tmsc_oen_o     (tmsc_oen_o)
    );

endmodule

`default_nettype wire

// File: verilog/cjtag_ctrl_fsm.sv
/*
 * Bridge controller FSM: offline, activation code check, OScan1
 * Tracks the packet position and the TMSC bit sampled on each fall
 */
`timescale 1ns/1ps
`default_nettype none

`include "cjtag_settings.svh"

module cjtag_ctrl_fsm (
    input  logic                   clk_i,
    input  logic                   ntrst_i,
    input  logic                   tmsc_lvl_i,
    input  logic                   tckc_fall_i,
    input  logic                   esc_select_i,
    input  logic                   esc_reset_i,
    output logic                   oscan_active_o,
    output cjtag_pkg::oscan1_pos_t pkt_pos_o,
    output logic                   tmsc_bit_o,
    output logic                   online_o,
    output logic                   nsp_o
);

    import cjtag_pkg::*;

    localparam int OAC_N     = `CJTAG_OAC_BITS;
    localparam int OAC_CNT_W = $clog2(OAC_N);

    localparam logic [OAC_N-1:0]     OAC_CODE = OAC_N'(`CJTAG_OAC);
    localparam logic [OAC_CNT_W-1:0] OAC_LAST = OAC_CNT_W'(OAC_N - 1);

    cjtag_state_t         state_q;
    oscan1_pos_t          pos_q;
    logic [OAC_CNT_W-1:0] oac_cnt_q;
    logic [OAC_N-2:0]     oac_shift_q;
    logic                 tmsc_bit_q;
    logic [OAC_N-1:0]     oac_word;

    // Last bit comes straight from the pin, earlier bits from the shifter
    assign oac_word = {tmsc_lvl_i, oac_shift_q};

    // Packet slots rotate nTDI, TMS, TDO
    function automatic oscan1_pos_t next_pos(input oscan1_pos_t pos);
        case (pos)
            POS_NTDI: next_pos = POS_TMS;
            POS_TMS:  next_pos = POS_TDO;
            default:  next_pos = POS_NTDI;
        endcase
    endfunction

    // ============================================================
    // Sampled data
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (tckc_fall_i) begin
            tmsc_bit_q <= tmsc_lvl_i;
            // Activation code arrives LSB first, shift in from the top
            if (state_q == ONLINE_ACT) begin
                oac_shift_q <= {tmsc_lvl_i, oac_shift_q[OAC_N-2:1]};
            end
        end
    end

    // ============================================================
    // State register
    // ============================================================

    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            state_q   <= OFFLINE;
            pos_q     <= POS_NTDI;
            oac_cnt_q <= '0;
        end else if (esc_reset_i) begin
            // Reset escape wins in every state
            state_q   <= OFFLINE;
            pos_q     <= POS_NTDI;
            oac_cnt_q <= '0;
        end else begin
            case (state_q)
                OFFLINE: begin
                    if (esc_select_i) begin
                        state_q   <= ONLINE_ACT;
                        oac_cnt_q <= '0;
                    end
                end
                ONLINE_ACT: begin
                    if (tckc_fall_i) begin
                        if (oac_cnt_q == OAC_LAST) begin
                            oac_cnt_q <= '0;
                            // Mismatch drops back to offline
                            if (oac_word == OAC_CODE) begin
                                state_q <= OSCAN1;
                                pos_q   <= POS_NTDI;
                            end else begin
                                state_q <= OFFLINE;
                            end
                        end else begin
                            oac_cnt_q <= oac_cnt_q + 1'b1;
                        end
                    end
                end
                OSCAN1: begin
                    if (tckc_fall_i) begin
                        pos_q <= next_pos(pos_q);
                    end
                end
                default: begin
                    state_q <= OFFLINE;
                end
            endcase
        end
    end

    // Status follows the state register directly
    assign oscan_active_o = (state_q == OSCAN1);
    assign online_o       = (state_q == OSCAN1);
    assign nsp_o          = (state_q != OSCAN1);
    assign pkt_pos_o      = pos_q;
    assign tmsc_bit_o     = tmsc_bit_q;

endmodule

`default_nettype wire

// File: verilog/cjtag_escape_detect.sv
/*
 * Escape sequence detector
 * Counts TMSC toggles while TCKC is high and classifies on the TCKC fall
 */
`timescale 1ns/1ps
`default_nettype none

`include "cjtag_settings.svh"

module cjtag_escape_detect (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic tckc_lvl_i,
    input  logic tckc_rise_i,
    input  logic tckc_fall_i,
    input  logic tmsc_edge_i,
    output logic esc_select_o,
    output logic esc_reset_o
);

    localparam int CNT_W = `CJTAG_TOGGLE_CNT_W;

    localparam logic [CNT_W-1:0] SEL_MIN = CNT_W'(`CJTAG_ESC_SELECT_MIN);
    localparam logic [CNT_W-1:0] SEL_MAX = CNT_W'(`CJTAG_ESC_SELECT_MAX);
    localparam logic [CNT_W-1:0] RST_MIN = CNT_W'(`CJTAG_ESC_RESET_MIN);

    logic             tckc_high_q;
    logic [CNT_W-1:0] toggle_cnt_q;
    logic             cnt_sat;

    // Counter stops at all ones so a long burst still reads as reset
    assign cnt_sat = &toggle_cnt_q;

    // ============================================================
    // Toggle counter
    // ============================================================

    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tckc_high_q  <= 1'b0;
            toggle_cnt_q <= '0;
        end else begin
            if (tckc_rise_i) begin
                // New high phase, start counting from zero
                tckc_high_q  <= 1'b1;
                toggle_cnt_q <= '0;
            end else if (tckc_fall_i) begin
                // Keep the count, it is classified this cycle
                tckc_high_q <= 1'b0;
            end else if (tckc_high_q && tckc_lvl_i && tmsc_edge_i && !cnt_sat) begin
                toggle_cnt_q <= toggle_cnt_q + 1'b1;
            end
        end
    end

    // ============================================================
    // Classification
    // ============================================================

    // Valid only in the fall cycle, runs in every controller state
    // 4-5 toggles (deselection) and other counts give no pulse
    assign esc_select_o = tckc_fall_i
                          && (toggle_cnt_q >= SEL_MIN)
                          && (toggle_cnt_q <= SEL_MAX);

    assign esc_reset_o  = tckc_fall_i && (toggle_cnt_q >= RST_MIN);

endmodule

`default_nettype wire

// File: verilog/cjtag_input_sync.sv
/*
 * Probe pin synchronizers with registered edge pulses
 * Levels lag the pins by 2 clocks, pulses by 3 clocks
 */
`timescale 1ns/1ps
`default_nettype none

`include "cjtag_settings.svh"

module cjtag_input_sync (
    input  logic clk_i,
    input  logic ntrst_i,
    input  logic tckc_i,
    input  logic tmsc_i,
    output logic tckc_lvl_o,
    output logic tmsc_lvl_o,
    output logic tckc_rise_o,
    output logic tckc_fall_o,
    output logic tmsc_edge_o
);

    localparam int SYNC_N = `CJTAG_SYNC_STAGES;

    // Both pins travel side by side, bit 1 is TCKC and bit 0 is TMSC
    logic [SYNC_N-1:0][1:0] sync_q;
    logic [1:0]             lvl;
    logic [1:0]             prev_q;
    logic                   rise_q;
    logic                   fall_q;
    logic                   edge_q;

    // ============================================================
    // Synchronizer chain
    // ============================================================

    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            sync_q <= '0;
        end else begin
            // Stage 0 takes the raw pins, last stage is the clean level
            sync_q <= {sync_q[SYNC_N-2:0], {tckc_i, tmsc_i}};
        end
    end

    assign lvl = sync_q[SYNC_N-1];

    // ============================================================
    // Edge pulses
    // ============================================================

    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            prev_q <= 2'b00;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
            edge_q <= 1'b0;
        end else begin
            prev_q <= lvl;
            // One clock wide, one clock after the level moves
            rise_q <= lvl[1] & ~prev_q[1];
            fall_q <= ~lvl[1] & prev_q[1];
            // TMSC counts both directions
            edge_q <= lvl[0] ^ prev_q[0];
        end
    end

    assign tckc_lvl_o  = lvl[1];
    assign tmsc_lvl_o  = lvl[0];
    assign tckc_rise_o = rise_q;
    assign tckc_fall_o = fall_q;
    assign tmsc_edge_o = edge_q;

endmodule

`default_nettype wire

// File: verilog/cjtag_pkg.sv
/*
 * Shared types of the cJTAG bridge
 * Controller state and OScan1 packet position
 */
`default_nettype none

package cjtag_pkg;

    // Controller state
    // OFFLINE waits for a selection escape
    // ONLINE_ACT receives the activation code
    // OSCAN1 moves 3-bit packets to the TAP
    typedef enum logic [1:0] {
        OFFLINE    = 2'b00,
        ONLINE_ACT = 2'b01,
        OSCAN1     = 2'b10
    } cjtag_state_t;

    // Bit slot within one OScan1 packet
    // POS_NTDI carries inverted TDI from the probe
    // POS_TMS carries TMS from the probe
    // POS_TDO is the TCK slot, bridge drives TDO back on TMSC
    typedef enum logic [1:0] {
        POS_NTDI = 2'b00,
        POS_TMS  = 2'b01,
        POS_TDO  = 2'b10
    } oscan1_pos_t;

endpackage

`default_nettype wire

// File: verilog/oscan1_tap_drive.sv
/*
 * JTAG pin generation for OScan1 packets
 * TCK pulse, TDI and TMS updates, TDO capture and TMSC direction control
 */
`timescale 1ns/1ps
`default_nettype none

module oscan1_tap_drive (
    input  logic                   clk_i,
    input  logic                   ntrst_i,
    input  logic                   oscan_active_i,
    input  cjtag_pkg::oscan1_pos_t pkt_pos_i,
    input  logic                   tmsc_bit_i,
    input  logic                   tckc_rise_i,
    input  logic                   tckc_fall_i,
    input  logic                   tdo_i,
    output logic                   tck_o,
    output logic                   tms_o,
    output logic                   tdi_o,
    output logic                   tmsc_o,
    output logic                   tmsc_oen_o
);

    import cjtag_pkg::*;

    logic tck_q;
    logic tms_q;
    logic tdi_q;
    logic oen_q;
    logic tdo_q;
    logic tdo_slot;

    // Third packet bit while the bridge is in OScan1
    assign tdo_slot = oscan_active_i && (pkt_pos_i == POS_TDO);

    // ============================================================
    // JTAG pins and TMSC direction
    // ============================================================

    always_ff @(posedge clk_i or negedge ntrst_i) begin
        if (!ntrst_i) begin
            tck_q <= 1'b0;
            tms_q <= 1'b1;
            tdi_q <= 1'b0;
            oen_q <= 1'b1;
        end else if (!oscan_active_i) begin
            // Idle TAP, probe owns TMSC
            tck_q <= 1'b0;
            tms_q <= 1'b1;
            tdi_q <= 1'b0;
            oen_q <= 1'b1;
        end else begin
            if (tckc_rise_i) begin
                case (pkt_pos_i)
                    POS_NTDI: begin
                        // Hand TMSC back to the probe for the next packet
                        oen_q <= 1'b1;
                    end
                    POS_TMS: begin
                        // nTDI was sampled on the previous fall
                        tdi_q <= ~tmsc_bit_i;
                        oen_q <= 1'b1;
                    end
                    POS_TDO: begin
                        // TMS is in, clock the TAP and turn TMSC around
                        tms_q <= tmsc_bit_i;
                        tck_q <= 1'b1;
                        oen_q <= 1'b0;
                    end
                    default: begin
                        oen_q <= 1'b1;
                    end
                endcase
            end
            // TCK low again at the end of the TDO bit
            if (tckc_fall_i && (pkt_pos_i == POS_TDO)) begin
                tck_q <= 1'b0;
            end
        end
    end

    // ============================================================
    // TDO capture
    // ============================================================

    // Sampled while TCK is high, first update one clock after the rise
    always_ff @(posedge clk_i) begin
        if (tck_q && tdo_slot) begin
            tdo_q <= tdo_i;
        end
    end

    assign tck_o      = tck_q;
    assign tms_o      = tms_q;
    assign tdi_o      = tdi_q;
    assign tmsc_oen_o = oen_q;
    // Driven value stays 0 whenever TMSC is an input
    assign tmsc_o     = (tdo_slot && !oen_q) ? tdo_q : 1'b0;

endmodule

`default_nettype wire
